//--- common/usb_pkg.sv
// usb protocol definitions
package usb_pkg;

   //============================================================
   // data pids
   //============================================================

   // four bit pid codes as the device core expects them
   typedef enum logic [3:0] {
      PID_DATA0 = 4'b0011,
      PID_DATA1 = 4'b1011,
      PID_DATA2 = 4'b0111
   } pid_t;

   //============================================================
   // control transfers
   //============================================================

   // eight byte setup packet, first byte on the wire in the top bits
   typedef struct packed {
      logic [7:0]  bm_request_type;
      logic [7:0]  b_request;
      logic [15:0] w_value;
      logic [15:0] w_index;
      logic [15:0] w_length;
   } setup_pkt_t;

   // bytes in one setup packet
   localparam int SETUP_BYTES = 8;

   //============================================================
   // endpoints
   //============================================================

   typedef logic [3:0] endpt_t;

   // default control pipe
   localparam endpt_t EP_CTRL  = 4'd0;
   // isochronous video in
   localparam endpt_t EP_VIDEO = 4'd2;

endpackage

//--- common/uvc_pkg.sv
// video class definitions
package uvc_pkg;

   //============================================================
   // class requests
   //============================================================

   localparam logic [7:0] SET_CUR = 8'h01;
   localparam logic [7:0] GET_CUR = 8'h81;
   localparam logic [7:0] GET_DEF = 8'h87;

   // control selector, w_value high byte
   localparam logic [7:0] VS_PROBE_CONTROL = 8'h01;
   // streaming interface number, w_index low byte
   localparam logic [7:0] VS_INTERFACE = 8'd1;

   //============================================================
   // probe block
   //============================================================

   localparam int PROBE_BYTES = 34;

   // fields listed last first so wire byte 0 sits in bits [7:0]
   // multi byte fields are little endian, matching the wire
   typedef struct packed {
      logic [7:0]  b_max_version;
      logic [7:0]  b_min_version;
      logic [7:0]  b_prefered_version;
      logic [7:0]  bm_framing_info;
      logic [31:0] dw_clock_frequency;
      logic [31:0] dw_max_payload_transfer_size;
      logic [31:0] dw_max_video_frame_size;
      logic [15:0] w_delay;
      logic [15:0] w_comp_window_size;
      logic [15:0] w_comp_quality;
      logic [15:0] w_p_frame_rate;
      logic [15:0] w_key_frame_rate;
      logic [31:0] dw_frame_interval;
      logic [7:0]  b_frame_index;
      logic [7:0]  b_format_index;
      logic [15:0] bm_hint;
   } probe_fields_t;

   // named fields for setup, byte array for serializing
   typedef union packed {
      probe_fields_t                 fields;
      logic [PROBE_BYTES-1:0][7:0]   bytes;
   } probe_block_u;

   //============================================================
   // fifo and payload sizing
   //============================================================

   // fill count width, holds 0 to FIFO_DEPTH
   localparam int LEVEL_W = 12;
   // buffer address width
   localparam int FIFO_AW = 11;

   localparam logic [LEVEL_W-1:0] FIFO_DEPTH   = 12'd2048;
   localparam logic [LEVEL_W-1:0] ISO_PAYLOAD  = 12'd1024;
   localparam logic [LEVEL_W-1:0] AFULL_LEVEL  = 12'd1024;
   localparam logic [LEVEL_W-1:0] AEMPTY_LEVEL = 12'd512;

   // 640x480 yuy2 frame, 30 fps interval in 100 ns units
   localparam probe_block_u PROBE_DEFAULT = probe_fields_t'{
      b_format_index:               8'd1,
      b_frame_index:                8'd1,
      dw_frame_interval:            32'd333333,
      dw_max_video_frame_size:      32'd614400,
      dw_max_payload_transfer_size: 32'(ISO_PAYLOAD),
      dw_clock_frequency:           32'd60000000,
      default:                      '0
   };

   // fifo fill state seen by the scheduler
   typedef struct packed {
      logic [LEVEL_W-1:0] count;
      logic               empty;
      logic               aempty;
      logic               afull;
   } fifo_level_t;

   // transmit request toward the device core
   typedef struct packed {
      logic [LEVEL_W-1:0] len;
      logic               cork;
      usb_pkg::pid_t      pid;
   } tx_req_t;

endpackage

//--- control/setup_parser.sv
// setup packet capture
`timescale 1ns/1ps

module setup_parser (
   input  logic                PHY_CLKOUT,
   input  logic                RESET_IN,
   input  logic                setup_active_i,
   input  logic                rxval_i,
   input  logic [7:0]          rxdat_i,
   output usb_pkg::setup_pkt_t setup_o,
   output logic                setup_done_o
);

   import usb_pkg::*;

   logic [3:0] byte_cnt;
   logic [3:0] byte_idx;
   logic       active_d;
   logic       active_rise;
   logic       take;
   setup_pkt_t setup_q;

   // new setup token restarts the count
   assign active_rise = setup_active_i & ~active_d;
   // index of the byte on the bus this cycle
   assign byte_idx    = active_rise ? 4'd0 : byte_cnt;
   assign take        = setup_active_i & rxval_i & (byte_idx < SETUP_BYTES);

   //============================================================
   // byte counter and done pulse
   //============================================================

   always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
      if (RESET_IN) begin
         active_d     <= 1'b0;
         byte_cnt     <= 4'd0;
         setup_done_o <= 1'b0;
      end else begin
         active_d     <= setup_active_i;
         // done follows the eighth byte by one cycle
         setup_done_o <= take & (byte_idx == 4'(SETUP_BYTES - 1));
         if (take) begin
            byte_cnt <= byte_idx + 4'd1;
         end else if (active_rise) begin
            byte_cnt <= 4'd0;
         end
      end
   end

   //============================================================
   // field steering
   //============================================================

   // bytes arrive low byte first for each word
   always_ff @(posedge PHY_CLKOUT) begin
      if (take) begin
         case (byte_idx)
            4'd0:    setup_q.bm_request_type <= rxdat_i;
            4'd1:    setup_q.b_request       <= rxdat_i;
            4'd2:    setup_q.w_value[7:0]    <= rxdat_i;
            4'd3:    setup_q.w_value[15:8]   <= rxdat_i;
            4'd4:    setup_q.w_index[7:0]    <= rxdat_i;
            4'd5:    setup_q.w_index[15:8]   <= rxdat_i;
            4'd6:    setup_q.w_length[7:0]   <= rxdat_i;
            default: setup_q.w_length[15:8]  <= rxdat_i;
         endcase
      end
   end

   assign setup_o = setup_q;

   // counter stops at a full packet until the next token
   a_cnt_bound: assert property (@(posedge PHY_CLKOUT) disable iff (RESET_IN)
      byte_cnt <= SETUP_BYTES);

endmodule

//--- control/probe_responder.sv
// probe control responder
`timescale 1ns/1ps

module probe_responder (
   input  logic                PHY_CLKOUT,
   input  logic                RESET_IN,
   input  usb_pkg::setup_pkt_t setup_i,
   input  logic                setup_done_i,
   input  logic                txact_i,
   input  logic                txpop_i,
   input  usb_pkg::endpt_t     endpt_i,
   output logic [7:0]          txdat_o,
   output logic                txval_o
);

   import usb_pkg::*;
   import uvc_pkg::*;

   probe_block_u probe;
   logic         is_probe_read;
   logic         pop;
   logic         last_pop;
   logic [5:0]   probe_idx;
   logic [5:0]   next_idx;

   // current settings are the defaults, no writeback
   assign probe = PROBE_DEFAULT;

   //============================================================
   // request decode
   //============================================================

   // get_cur or get_def of the probe selector on the streaming interface
   assign is_probe_read = ((setup_i.b_request == GET_CUR) ||
                           (setup_i.b_request == GET_DEF)) &&
                          (setup_i.w_index[7:0] == VS_INTERFACE) &&
                          (setup_i.w_value[15:8] == VS_PROBE_CONTROL);

   // core takes a byte on endpoint 0
   assign pop      = txval_o & txact_i & txpop_i & (endpt_i == EP_CTRL);
   assign last_pop = pop & (probe_idx == 6'(PROBE_BYTES - 1));
   assign next_idx = probe_idx + 6'd1;

   //============================================================
   // serializer
   //============================================================

   always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
      if (RESET_IN) begin
         txval_o   <= 1'b0;
         probe_idx <= 6'd0;
      end else if (setup_done_i) begin
         // arm on a matching request, any other request disarms
         txval_o   <= is_probe_read;
         probe_idx <= 6'd0;
      end else if (last_pop) begin
         txval_o   <= 1'b0;
         probe_idx <= 6'd0;
      end else if (pop) begin
         probe_idx <= next_idx;
      end
   end

   // byte register follows the index, holds without a pop
   always_ff @(posedge PHY_CLKOUT) begin
      if (setup_done_i) begin
         txdat_o <= probe.bytes[0];
      end else if (pop && !last_pop) begin
         txdat_o <= probe.bytes[next_idx];
      end
   end

   // index stays inside the block for the whole data stage
   a_idx_range: assert property (@(posedge PHY_CLKOUT) disable iff (RESET_IN)
      txval_o |-> (probe_idx < PROBE_BYTES));

endmodule

//--- video/payload_fifo.sv
// payload byte fifo
`timescale 1ns/1ps

module payload_fifo (
   input  logic                PHY_CLKOUT,
   input  logic                RESET_IN,
   input  logic                wr_valid_i,
   input  logic [7:0]          wr_data_i,
   output logic                wr_ready_o,
   input  logic                pop_i,
   output logic [7:0]          head_o,
   output uvc_pkg::fifo_level_t level_o
);

   import uvc_pkg::*;

   logic [7:0]         mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [LEVEL_W-1:0] count;
   logic               push;
   logic               pull;

   // ready drops only at a full buffer
   assign wr_ready_o = (count != FIFO_DEPTH);
   assign push       = wr_valid_i & wr_ready_o;
   assign pull       = pop_i & ~level_o.empty;

   //============================================================
   // pointers and fill count
   //============================================================

   always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
      if (RESET_IN) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pull) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // simultaneous push and pull leaves the count alone
         case ({push, pull})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   //============================================================
   // storage
   //============================================================

   always_ff @(posedge PHY_CLKOUT) begin
      if (push) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   // fall through read, head moves the cycle after a pop
   assign head_o = mem[rd_ptr];

   // level flags for the scheduler
   assign level_o.count  = count;
   assign level_o.empty  = (count == '0);
   assign level_o.aempty = (count < AEMPTY_LEVEL);
   assign level_o.afull  = (count >= AFULL_LEVEL);

   // core must not read past the last byte
   a_no_underrun: assert property (@(posedge PHY_CLKOUT) disable iff (RESET_IN)
      pop_i |-> !level_o.empty);

endmodule

//--- video/iso_scheduler.sv
// isochronous transfer scheduler
`timescale 1ns/1ps

module iso_scheduler (
   input  logic                 PHY_CLKOUT,
   input  logic                 RESET_IN,
   input  uvc_pkg::fifo_level_t level_i,
   input  usb_pkg::endpt_t      endpt_i,
   input  logic                 txact_i,
   input  logic                 sof_i,
   output uvc_pkg::tx_req_t     tx_req_o
);

   import usb_pkg::*;
   import uvc_pkg::*;

   logic [LEVEL_W-1:0] len_q;
   logic               cork_q;
   pid_t               pid_q;
   logic               txact_d;
   logic               video_done;

   // end of an in transaction on the video endpoint
   assign video_done = txact_d & ~txact_i & (endpt_i == EP_VIDEO);

   //============================================================
   // length and cork
   //============================================================

   always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
      if (RESET_IN) begin
         len_q  <= LEVEL_W'(PROBE_BYTES);
         cork_q <= 1'b0;
      end else if (txact_i) begin
         // hold during the transaction, control length is spent
         if (endpt_i == EP_CTRL) begin
            len_q <= '0;
         end
      end else if (endpt_i == EP_CTRL) begin
         len_q  <= LEVEL_W'(PROBE_BYTES);
         cork_q <= 1'b0;
      end else if (endpt_i == EP_VIDEO) begin
         if (level_i.afull) begin
            len_q  <= ISO_PAYLOAD;
            cork_q <= 1'b0;
         end else if (level_i.empty) begin
            // nothing to send, zero length
            len_q  <= '0;
            cork_q <= 1'b1;
         end else if (level_i.aempty) begin
            // short packet drains what is left
            len_q  <= level_i.count;
            cork_q <= 1'b0;
         end else begin
            len_q  <= ISO_PAYLOAD;
            cork_q <= 1'b0;
         end
      end else begin
         len_q  <= '0;
         cork_q <= 1'b1;
      end
   end

   //============================================================
   // high bandwidth pid, three packets per microframe
   //============================================================

   always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
      if (RESET_IN) begin
         txact_d <= 1'b0;
         pid_q   <= PID_DATA2;
      end else begin
         txact_d <= txact_i;
         if (sof_i) begin
            // start pid sets how many packets this microframe carries
            if (level_i.afull) begin
               pid_q <= PID_DATA2;
            end else if (level_i.aempty) begin
               pid_q <= PID_DATA0;
            end else begin
               pid_q <= PID_DATA1;
            end
         end else if (video_done) begin
            // count down, data0 is the last packet
            case (pid_q)
               PID_DATA2: pid_q <= PID_DATA1;
               PID_DATA1: pid_q <= PID_DATA0;
               default:   pid_q <= PID_DATA0;
            endcase
         end
      end
   end

   assign tx_req_o.len  = len_q;
   assign tx_req_o.cork = cork_q;
   assign tx_req_o.pid  = pid_q;

   a_pid_legal: assert property (@(posedge PHY_CLKOUT) disable iff (RESET_IN)
      pid_q inside {PID_DATA0, PID_DATA1, PID_DATA2});

endmodule

//--- source/uvc_endpoint_top.sv
// video class endpoint top
`timescale 1ns/1ps

module uvc_endpoint_top (
   input  logic             PHY_CLKOUT,
   input  logic             RESET_IN,
   // device core side
   input  logic             setup_active_i,
   input  logic             rxval_i,
   input  logic [7:0]       rxdat_i,
   input  logic             txact_i,
   input  logic             txpop_i,
   input  usb_pkg::endpt_t  endpt_i,
   input  logic             sof_i,
   input  logic [7:0]       inf_sel_i,
   input  logic [7:0]       inf_alter_i,
   input  logic             inf_set_i,
   output logic [7:0]       txdat_o,
   output logic             txval_o,
   output uvc_pkg::tx_req_t tx_req_o,
   output logic [7:0]       inf_alter_o,
   // frame source side
   input  logic             frame_valid_i,
   input  logic [7:0]       frame_data_i,
   output logic             frame_ready_o
);

   import usb_pkg::*;
   import uvc_pkg::*;

   setup_pkt_t  setup;
   logic        setup_done;
   logic [7:0]  probe_dat;
   logic        probe_val;
   logic [7:0]  fifo_head;
   logic        fifo_pop;
   fifo_level_t fifo_level;
   logic [7:0]  alt0_q;
   logic [7:0]  alt1_q;

   //============================================================
   // control endpoint
   //============================================================

   setup_parser u_setup_parser (
      .PHY_CLKOUT     (PHY_CLKOUT),
      .RESET_IN       (RESET_IN),
      .setup_active_i (setup_active_i),
      .rxval_i        (rxval_i),
      .rxdat_i        (rxdat_i),
      .setup_o        (setup),
      .setup_done_o   (setup_done)
   );

   probe_responder u_probe_responder (
      .PHY_CLKOUT   (PHY_CLKOUT),
      .RESET_IN     (RESET_IN),
      .setup_i      (setup),
      .setup_done_i (setup_done),
      .txact_i      (txact_i),
      .txpop_i      (txpop_i),
      .endpt_i      (endpt_i),
      .txdat_o      (probe_dat),
      .txval_o      (probe_val)
   );

   //============================================================
   // video endpoint
   //============================================================

   // one byte leaves per pop on the video pipe
   assign fifo_pop = txact_i & txpop_i & (endpt_i == EP_VIDEO);

   payload_fifo u_payload_fifo (
      .PHY_CLKOUT (PHY_CLKOUT),
      .RESET_IN   (RESET_IN),
      .wr_valid_i (frame_valid_i),
      .wr_data_i  (frame_data_i),
      .wr_ready_o (frame_ready_o),
      .pop_i      (fifo_pop),
      .head_o     (fifo_head),
      .level_o    (fifo_level)
   );

   iso_scheduler u_iso_scheduler (
      .PHY_CLKOUT (PHY_CLKOUT),
      .RESET_IN   (RESET_IN),
      .level_i    (fifo_level),
      .endpt_i    (endpt_i),
      .txact_i    (txact_i),
      .sof_i      (sof_i),
      .tx_req_o   (tx_req_o)
   );

   // control pipe sends probe bytes, video pipe streams the fifo head
   assign txdat_o = (endpt_i == EP_CTRL) ? probe_dat : fifo_head;
   // iso data is pulled by length, only control needs valid
   assign txval_o = (endpt_i == EP_CTRL) ? probe_val : 1'b0;

   //============================================================
   // alternate settings
   //============================================================

   always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
      if (RESET_IN) begin
         alt0_q <= 8'd0;
         alt1_q <= 8'd0;
      end else if (inf_set_i) begin
         if (inf_sel_i == 8'd0) begin
            alt0_q <= inf_alter_i;
         end else if (inf_sel_i == 8'd1) begin
            alt1_q <= inf_alter_i;
         end
      end
   end

   // unknown interfaces read as setting 0
   assign inf_alter_o = (inf_sel_i == 8'd0) ? alt0_q :
                        (inf_sel_i == 8'd1) ? alt1_q : 8'd0;

endmodule

//--- dv/tb_uvc_endpoint.sv
// video endpoint testbench
`timescale 1ns/1ps

module tb_uvc_endpoint;

   import usb_pkg::*;
   import uvc_pkg::*;

   logic             PHY_CLKOUT;
   logic             RESET_IN;
   logic             setup_active_i;
   logic             rxval_i;
   logic [7:0]       rxdat_i;
   logic             txact_i;
   logic             txpop_i;
   endpt_t           endpt_i;
   logic             sof_i;
   logic [7:0]       inf_sel_i;
   logic [7:0]       inf_alter_i;
   logic             inf_set_i;
   logic [7:0]       txdat_o;
   logic             txval_o;
   tx_req_t          tx_req_o;
   logic [7:0]       inf_alter_o;
   logic             frame_valid_i;
   logic [7:0]       frame_data_i;
   logic             frame_ready_o;

   // expected probe bytes in wire order
   logic [7:0]       probe_ref [PROBE_BYTES];
   // bytes written but not yet popped
   logic [7:0]       exp_q [$];
   logic [7:0]       exp_head;
   logic             check_head;
   logic             quiet_ctrl;
   int               fill;

   uvc_endpoint_top uut (.*);

   // 50 MHz
   always #10 PHY_CLKOUT = ~PHY_CLKOUT;

   //============================================================
   // failure reporting and checks
   //============================================================

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      abort_run($sformatf("FAIL %s expected 0x%0h actual 0x%0h", name, exp, act));
   endtask

   task automatic check_eq(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
      assert (act === exp) else report_mismatch(name, exp, act);
   endtask

   // no probe data for a rejected request
   a_ctrl_quiet: assert property (@(posedge PHY_CLKOUT) disable iff (RESET_IN)
      quiet_ctrl |-> !txval_o)
      else abort_run("txval_o raised after a request that is not a probe read");

   // popped byte must be the oldest written one
   a_head_order: assert property (@(posedge PHY_CLKOUT) disable iff (RESET_IN)
      check_head |-> (txdat_o == exp_head))
      else report_mismatch("fifo order", $sampled(exp_head), $sampled(txdat_o));

   // ready only drops with 2048 bytes held
   a_ready_full: assert property (@(posedge PHY_CLKOUT) disable iff (RESET_IN)
      !frame_ready_o |-> (fill == 2048))
      else abort_run("frame_ready_o low while the FIFO is not full");

   //============================================================
   // stimulus helpers
   //============================================================

   // drive inputs 1 ns after the edge
   task automatic tick();
      @(posedge PHY_CLKOUT);
      #1;
   endtask

   // sample at the falling edge
   task automatic mid();
      @(negedge PHY_CLKOUT);
   endtask

   task automatic put_le(input int ofs, input logic [31:0] val, input int n);
      int i;
      for (i = 0; i < n; i++) begin
         probe_ref[ofs + i] = val[8*i +: 8];
      end
   endtask

   // eight bytes with the low byte of each word first
   task automatic send_setup(input logic [7:0] req_type, input logic [7:0] req,
                             input logic [15:0] wval, input logic [15:0] widx);
      logic [7:0] pkt [8];
      int         i;
      pkt = '{req_type, req, wval[7:0], wval[15:8], widx[7:0], widx[15:8], 8'd34, 8'd0};
      for (i = 0; i < 8; i++) begin
         setup_active_i = 1'b1;
         rxval_i        = 1'b1;
         rxdat_i        = pkt[i];
         tick();
      end
      setup_active_i = 1'b0;
      rxval_i        = 1'b0;
   endtask

   task automatic await_probe(input string name);
      int n;
      n = 0;
      mid();
      while (txval_o !== 1'b1) begin
         if (n == 16) abort_run({name, " probe data stage never started"});
         n++;
         mid();
      end
      tick();
   endtask

   // one pop per two cycles on endpoint 0
   task automatic read_probe(input string name);
      int k;
      endpt_i = EP_CTRL;
      txact_i = 1'b1;
      for (k = 0; k < PROBE_BYTES; k++) begin
         mid();
         check_eq({name, " txval"}, 1, txval_o);
         check_eq($sformatf("%s byte %0d", name, k), probe_ref[k], txdat_o);
         tick();
         txpop_i = 1'b1;
         tick();
         txpop_i = 1'b0;
      end
      mid();
      check_eq({name, " txval after last pop"}, 0, txval_o);
      tick();
      txact_i = 1'b0;
   endtask

   task automatic idle_ctrl_txn(input string name);
      int i;
      // covers setup_done plus arming
      repeat (4) tick();
      endpt_i = EP_CTRL;
      txact_i = 1'b1;
      txpop_i = 1'b1;
      for (i = 0; i < 4; i++) begin
         mid();
         check_eq(name, 0, txval_o);
         tick();
      end
      txpop_i = 1'b0;
      txact_i = 1'b0;
      tick();
   endtask

   task automatic push_bytes(input int n);
      int i;
      int waited;
      for (i = 0; i < n; i++) begin
         frame_valid_i = 1'b1;
         frame_data_i  = 8'($urandom);
         waited        = 0;
         mid();
         while (frame_ready_o !== 1'b1) begin
            if (waited == 64) abort_run("frame_ready_o stuck low during a write");
            waited++;
            mid();
         end
         exp_q.push_back(frame_data_i);
         fill++;
         tick();
      end
      frame_valid_i = 1'b0;
   endtask

   // one isochronous transaction with a pop every cycle
   task automatic pop_bytes(input int n);
      int i;
      endpt_i = EP_VIDEO;
      txact_i = 1'b1;
      for (i = 0; i < n; i++) begin
         if (exp_q.size() == 0) abort_run("pop requested with no bytes written");
         txpop_i    = 1'b1;
         check_head = 1'b1;
         exp_head   = exp_q.pop_front();
         tick();
         fill--;
      end
      txpop_i    = 1'b0;
      check_head = 1'b0;
      txact_i    = 1'b0;
   endtask

   task automatic pulse_sof();
      sof_i = 1'b1;
      tick();
      sof_i = 1'b0;
   endtask

   // scheduler answers one cycle after the level settles
   task automatic check_req(input string name, input int len, input logic cork);
      tick();
      mid();
      check_eq({name, " len"}, len, tx_req_o.len);
      check_eq({name, " cork"}, cork, tx_req_o.cork);
      tick();
   endtask

   task automatic check_pid(input string name, input pid_t pid);
      tick();
      mid();
      check_eq({name, " pid"}, pid, tx_req_o.pid);
      tick();
   endtask

   task automatic set_alt(input logic [7:0] inf, input logic [7:0] alt);
      inf_sel_i   = inf;
      inf_alter_i = alt;
      inf_set_i   = 1'b1;
      tick();
      inf_set_i   = 1'b0;
   endtask

   //============================================================
   // watchdog
   //============================================================

   initial begin
      repeat (240000) @(posedge PHY_CLKOUT);
      abort_run("watchdog expired before the tests completed");
   end

   //============================================================
   // test sequence
   //============================================================

   initial begin
      PHY_CLKOUT     = 1'b0;
      RESET_IN       = 1'b1;
      setup_active_i = 1'b0;
      rxval_i        = 1'b0;
      rxdat_i        = 8'd0;
      txact_i        = 1'b0;
      txpop_i        = 1'b0;
      endpt_i        = EP_CTRL;
      sof_i          = 1'b0;
      inf_sel_i      = 8'd0;
      inf_alter_i    = 8'd0;
      inf_set_i      = 1'b0;
      frame_valid_i  = 1'b0;
      frame_data_i   = 8'd0;
      exp_head       = 8'd0;
      check_head     = 1'b0;
      quiet_ctrl     = 1'b0;
      fill           = 0;
      void'($urandom(80));

      // probe defaults at their wire offsets
      foreach (probe_ref[i]) probe_ref[i] = 8'd0;
      put_le(2, 1, 1);
      put_le(3, 1, 1);
      put_le(4, 333333, 4);
      put_le(18, 614400, 4);
      put_le(22, 1024, 4);
      put_le(26, 60000000, 4);

      repeat (16) @(posedge PHY_CLKOUT);
      #1;
      RESET_IN = 1'b0;

      // reset state
      mid();
      check_eq("reset txval", 0, txval_o);
      check_eq("reset len", 34, tx_req_o.len);
      check_eq("reset cork", 0, tx_req_o.cork);
      check_eq("reset pid", PID_DATA2, tx_req_o.pid);
      check_eq("reset ready", 1, frame_ready_o);
      check_eq("reset alt", 0, inf_alter_o);
      tick();

      // probe reads
      send_setup(8'hA1, 8'h81, 16'h0100, 16'h0001);
      await_probe("get_cur");
      read_probe("get_cur");
      send_setup(8'hA1, 8'h87, 16'h0100, 16'h0001);
      await_probe("get_def");
      read_probe("get_def");

      // rejected requests
      quiet_ctrl = 1'b1;
      send_setup(8'h21, 8'h01, 16'h0100, 16'h0001);
      idle_ctrl_txn("set_cur idle");
      send_setup(8'hA1, 8'h81, 16'h0200, 16'h0001);
      idle_ctrl_txn("wrong selector idle");
      send_setup(8'hA1, 8'h81, 16'h0100, 16'h0000);
      idle_ctrl_txn("interface 0 idle");
      quiet_ctrl = 1'b0;

      // length and cork from the fill level
      endpt_i = EP_VIDEO;
      check_req("empty", 0, 1'b1);
      push_bytes(300);
      check_req("short", 300, 1'b0);
      push_bytes(820);
      check_req("full", 1024, 1'b0);

      // pid countdown within a high bandwidth microframe
      pulse_sof();
      check_pid("sof afull", PID_DATA2);
      pop_bytes(16);
      check_pid("first txn", PID_DATA1);
      pop_bytes(16);
      check_pid("second txn", PID_DATA0);
      pop_bytes(16);
      check_pid("third txn", PID_DATA0);
      pop_bytes(372);
      check_req("middle level", 1024, 1'b0);
      pulse_sof();
      check_pid("sof middle", PID_DATA1);
      push_bytes(400);
      pulse_sof();
      check_pid("sof refill", PID_DATA2);
      pop_bytes(800);
      check_pid("drain txn", PID_DATA1);
      pulse_sof();
      check_pid("sof aempty", PID_DATA0);
      pop_bytes(300);
      check_req("drained", 0, 1'b1);

      // back-pressure at a full buffer
      push_bytes(2048);
      frame_valid_i = 1'b1;
      frame_data_i  = 8'($urandom);
      repeat (4) begin
         mid();
         check_eq("ready at full", 0, frame_ready_o);
         tick();
      end
      frame_valid_i = 1'b0;
      pop_bytes(2048);
      check_req("drained again", 0, 1'b1);

      // alternate settings
      set_alt(8'd0, 8'd3);
      set_alt(8'd1, 8'd5);
      inf_sel_i = 8'd0;
      mid();
      check_eq("alt interface 0", 3, inf_alter_o);
      tick();
      inf_sel_i = 8'd1;
      mid();
      check_eq("alt interface 1", 5, inf_alter_o);
      tick();
      inf_sel_i = 8'd2;
      mid();
      check_eq("alt interface 2", 0, inf_alter_o);
      tick();

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

//--- vlog.f
common/usb_pkg.sv
common/uvc_pkg.sv
control/setup_parser.sv
control/probe_responder.sv
video/payload_fifo.sv
video/iso_scheduler.sv
source/uvc_endpoint_top.sv
dv/tb_uvc_endpoint.sv

//--- Bender.yml
package:
  name: uvc_endpoint

sources:
  - files:
      - common/usb_pkg.sv
      - common/uvc_pkg.sv
      - control/setup_parser.sv
      - control/probe_responder.sv
      - video/payload_fifo.sv
      - video/iso_scheduler.sv
      - source/uvc_endpoint_top.sv
  - target: test
    files:
      - dv/tb_uvc_endpoint.sv
